//--- all.f
verilog/ex_pkg.sv
verilog/ex_alu.sv
verilog/ex_branch_unit.sv
verilog/ex_csr_buffer.sv
verilog/ex_multiplier.sv
verilog/ex_stage.sv
sim/tb_ex_stage.sv

//--- Bender.yml
package:
  name: ex_stage

sources:
  # Package first, units before the top level
  - verilog/ex_pkg.sv
  - verilog/ex_alu.sv
  - verilog/ex_branch_unit.sv
  - verilog/ex_csr_buffer.sv
  - verilog/ex_multiplier.sv
  - verilog/ex_stage.sv
  - target: simulation
    files:
      - sim/tb_ex_stage.sv

//--- sim/tb_ex_stage.sv
// Testbench of the execute stage, LFSR stimulus checked against a reference model by assertions
`timescale 1ns/10ps

module tb_ex_stage;
    import ex_pkg::*;

    localparam int N_ALU    = 40;
    localparam int N_BRANCH = 40;
    localparam int N_JUMP   = 20;
    localparam int N_STRAY  = 10;
    localparam int N_CSR    = 8;
    localparam int N_MUL    = 30;
    // Worst case cycles, reset and two closing cycles per test included
    localparam int RUN_CYCLES = 16 + N_ALU + N_BRANCH + N_JUMP + N_STRAY + 5 * N_CSR
                              + 2 * N_MUL + 6 * 2;

    logic                     clk_i = 1'b0;
    logic                     rst_ni;
    logic                     flush_i;
    fu_data_t                 fu_data_i;
    xlen_t                    pc_i;
    logic                     is_compressed_i;
    logic                     alu_valid_i;
    logic                     branch_valid_i;
    logic                     csr_valid_i;
    logic                     mult_valid_i;
    logic                     csr_commit_i;
    branch_predict_t          branch_predict_i;
    xlen_t                    flu_result_o;
    trans_id_t                flu_trans_id_o;
    exception_t               flu_exception_o;
    logic                     flu_valid_o;
    logic                     flu_ready_o;
    bp_resolve_t              resolved_branch_o;
    logic                     resolve_branch_o;
    logic [CSR_ADDR_BITS-1:0] csr_addr_o;

    logic [31:0] lfsr_q = 32'd17;
    int          err_cnt = 0;
    int          err_base = 0;
    int          tests_run = 0;
    int          tests_bad = 0;

    ex_stage dut_i (.*);

    always #2 clk_i = ~clk_i;

    // ----------------------------------------
    // Reference model
    // ----------------------------------------
    xlen_t                    op_a;
    xlen_t                    op_b;
    logic [63:0]              prod_u;
    logic signed [63:0]       prod_s;
    xlen_t                    m_alu;
    xlen_t                    m_mul;
    xlen_t                    m_link;
    xlen_t                    m_target;
    logic                     m_taken;
    logic                     m_valid;
    xlen_t                    m_result;
    trans_id_t                m_id;
    logic                     m_resolve;
    bp_resolve_t              m_rb;
    exception_t               m_exc;
    logic                     m_ready;
    // Product in flight, CSR entry held
    logic                     mq_valid;
    xlen_t                    mq_result;
    trans_id_t                mq_id;
    logic                     csr_full;
    logic [CSR_ADDR_BITS-1:0] csr_addr_m;

    always_comb begin
        op_a     = fu_data_i.operand_a;
        op_b     = fu_data_i.operand_b;
        m_link   = pc_i + (is_compressed_i ? 32'd2 : 32'd4);
        // JALR register relative with bit 0 cleared, others PC relative
        m_target = (fu_data_i.operation == JALR) ? (op_a + fu_data_i.imm) & ~32'd1
                                                 : pc_i + fu_data_i.imm;
        prod_u   = {32'd0, op_a} * {32'd0, op_b};
        prod_s   = $signed({{32{op_a[31]}}, op_a}) * $signed({{32{op_b[31]}}, op_b});
        m_alu    = '0;
        m_mul    = '0;
        m_taken  = 1'b0;
        case (fu_data_i.operation)
            ADD:       m_alu = op_a + op_b;
            SUB:       m_alu = op_a - op_b;
            XORL:      m_alu = op_a ^ op_b;
            ORL:       m_alu = op_a | op_b;
            ANDL:      m_alu = op_a & op_b;
            SLL:       m_alu = op_a << op_b[4:0];
            SRL:       m_alu = op_a >> op_b[4:0];
            SRA:       m_alu = $signed(op_a) >>> op_b[4:0];
            SLTS:      m_alu = xlen_t'($signed(op_a) < $signed(op_b));
            SLTU:      m_alu = xlen_t'(op_a < op_b);
            EQ:        m_taken = (op_a == op_b);
            NE:        m_taken = (op_a != op_b);
            LTS:       m_taken = $signed(op_a) < $signed(op_b);
            GES:       m_taken = $signed(op_a) >= $signed(op_b);
            LTU:       m_taken = op_a < op_b;
            GEU:       m_taken = op_a >= op_b;
            JAL, JALR: m_taken = 1'b1;
            MUL:       m_mul = prod_u[31:0];
            MULH:      m_mul = prod_s[63:32];
            MULHU:     m_mul = prod_u[63:32];
            default:   m_alu = '0;
        endcase

        // Write-back, product of the last cycle unless flushed
        m_valid  = alu_valid_i | branch_valid_i | csr_valid_i | (mq_valid & ~flush_i);
        m_result = mq_result;
        m_id     = mq_id;
        if (alu_valid_i | branch_valid_i | csr_valid_i) begin
            m_id     = fu_data_i.trans_id;
            m_result = alu_valid_i ? m_alu : (csr_valid_i ? op_a : m_link);
        end

        // Stray prediction sends the front end back to the link value
        m_resolve = branch_valid_i
                  | (branch_predict_i.valid & (alu_valid_i | csr_valid_i | mult_valid_i));
        m_rb                = '0;
        m_rb.valid          = 1'b1;
        m_rb.pc             = pc_i;
        m_rb.target_address = m_link;
        m_rb.is_mispredict  = 1'b1;
        if (branch_valid_i) begin
            m_rb.is_taken       = m_taken;
            m_rb.target_address = m_taken ? m_target : m_link;
            m_rb.is_mispredict  = (branch_predict_i.valid != m_taken)
                || (m_taken && (branch_predict_i.predict_address != m_target));
        end

        // Taken target off a 4-byte boundary
        m_exc = '0;
        if (branch_valid_i && m_taken && m_target[1]) begin
            m_exc.valid = 1'b1;
            m_exc.cause = EXC_INSTR_MISALIGNED;
            m_exc.tval  = m_target;
        end
        m_ready = ~csr_full | csr_commit_i;
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mq_valid <= 1'b0;
            csr_full <= 1'b0;
        end else begin
            mq_valid  <= mult_valid_i & ~flush_i;
            mq_result <= m_mul;
            mq_id     <= fu_data_i.trans_id;
            csr_full  <= flush_i ? 1'b0 : (csr_valid_i ? 1'b1 : (csr_commit_i ? 1'b0 : csr_full));
            if (csr_valid_i) begin
                csr_addr_m <= op_b[CSR_ADDR_BITS-1:0];
            end
        end
    end

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    assert property (@(posedge clk_i) disable iff (!rst_ni) flu_valid_o == m_valid)
        else report_mismatch("flu_valid_o", $sampled(flu_valid_o), $sampled(m_valid));
    assert property (@(posedge clk_i) disable iff (!rst_ni) m_valid |-> flu_result_o == m_result)
        else report_mismatch("flu_result_o", $sampled(flu_result_o), $sampled(m_result));
    assert property (@(posedge clk_i) disable iff (!rst_ni) m_valid |-> flu_trans_id_o == m_id)
        else report_mismatch("flu_trans_id_o", $sampled(flu_trans_id_o), $sampled(m_id));
    assert property (@(posedge clk_i) disable iff (!rst_ni) resolve_branch_o == m_resolve)
        else report_mismatch("resolve_branch_o", $sampled(resolve_branch_o), $sampled(m_resolve));
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        m_resolve |-> resolved_branch_o == m_rb)
        else report_mismatch("resolved_branch_o", $sampled(resolved_branch_o), $sampled(m_rb));
    // Cause and tval only matter on a raised exception
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        m_exc.valid ? (flu_exception_o == m_exc) : !flu_exception_o.valid)
        else report_mismatch("flu_exception_o", $sampled(flu_exception_o), $sampled(m_exc));
    assert property (@(posedge clk_i) disable iff (!rst_ni) flu_ready_o == m_ready)
        else report_mismatch("flu_ready_o", $sampled(flu_ready_o), $sampled(m_ready));
    assert property (@(posedge clk_i) disable iff (!rst_ni) csr_full |-> csr_addr_o == csr_addr_m)
        else report_mismatch("csr_addr_o", $sampled(csr_addr_o), $sampled(csr_addr_m));

    // ----------------------------------------
    // Helpers
    // ----------------------------------------
    // Right-shifting Galois LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
    endtask

    task automatic report_mismatch(input string name, input logic [127:0] got,
                                   input logic [127:0] exp);
        err_cnt++;
        $display("** Error @ %0d ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
    endtask

    // One instruction, strobes as {mult, csr, branch, alu}
    task automatic issue(input fu_op_e op, input logic [3:0] strb, input logic predict);
        fu_data_t        d;
        branch_predict_t bp;
        xlen_t           pc;
        logic [31:0]     r;
        d.operation = op;
        draw_bits(32, d.operand_a);
        draw_bits(32, d.operand_b);
        draw_bits(31, r);
        pc = {r[30:0], 1'b0};
        // imm, ID, compressed, equal operands, prediction bits
        draw_bits(21, r);
        d.imm      = {{20{r[11]}}, r[11:1], 1'b0};
        d.trans_id = r[14:12];
        if (r[17:16] == 2'd0) begin
            d.operand_b = d.operand_a;
        end
        bp = '0;
        if (predict) begin
            bp.valid = (r[19:18] != 2'd0);
            draw_bits(32, bp.predict_address);
            // Half the predictions hit the real target
            if (r[20]) begin
                bp.predict_address = (op == JALR) ? (d.operand_a + d.imm) & ~32'd1 : pc + d.imm;
            end
        end
        @(posedge clk_i);
        fu_data_i        <= d;
        pc_i             <= pc;
        is_compressed_i  <= r[15];
        branch_predict_i <= bp;
        alu_valid_i      <= strb[0];
        branch_valid_i   <= strb[1];
        csr_valid_i      <= strb[2];
        mult_valid_i     <= strb[3];
        csr_commit_i     <= 1'b0;
        flush_i          <= 1'b0;
    endtask

    // Cycle without issue, commit or flush on request
    task automatic drive_idle(input logic commit, input logic flush);
        @(posedge clk_i);
        alu_valid_i      <= 1'b0;
        branch_valid_i   <= 1'b0;
        csr_valid_i      <= 1'b0;
        mult_valid_i     <= 1'b0;
        branch_predict_i <= '0;
        csr_commit_i     <= commit;
        flush_i          <= flush;
    endtask

    // Lets the last check fire, then one line per test
    task automatic close_test(input string name);
        drive_idle(1'b0, 1'b0);
        @(posedge clk_i);
        #1;
        tests_run++;
        if (err_cnt != err_base) begin
            tests_bad++;
        end
        $display("Test %-8s finished, %0d mismatches", name, err_cnt - err_base);
        err_base = err_cnt;
    endtask

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    initial begin
        logic [31:0] r;
        rst_ni           <= 1'b0;
        flush_i          <= 1'b0;
        fu_data_i        <= '0;
        pc_i             <= '0;
        is_compressed_i  <= 1'b0;
        alu_valid_i      <= 1'b0;
        branch_valid_i   <= 1'b0;
        csr_valid_i      <= 1'b0;
        mult_valid_i     <= 1'b0;
        csr_commit_i     <= 1'b0;
        branch_predict_i <= '0;
        repeat (16) @(posedge clk_i);
        rst_ni <= 1'b1;

        repeat (N_ALU) begin
            draw_bits(4, r);
            issue(fu_op_e'(r % 10), 4'b0001, 1'b0);
        end
        close_test("alu");
        // EQ through GEU
        repeat (N_BRANCH) begin
            draw_bits(3, r);
            issue(fu_op_e'(EQ + r % 6), 4'b0010, 1'b1);
        end
        close_test("branch");
        repeat (N_JUMP) begin
            draw_bits(1, r);
            issue(r[0] ? JALR : JAL, 4'b0010, 1'b1);
        end
        close_test("jump");
        repeat (N_STRAY) begin
            draw_bits(4, r);
            issue(fu_op_e'(r % 10), 4'b0001, 1'b1);
        end
        close_test("stray");
        // Hold the entry zero to three cycles, then commit or flush
        repeat (N_CSR) begin
            issue(CSR_RW, 4'b0100, 1'b0);
            draw_bits(3, r);
            repeat (r[1:0]) drive_idle(1'b0, 1'b0);
            drive_idle(~r[2], r[2]);
        end
        close_test("csr");
        // Back to back, gap, or flush of the product in flight
        repeat (N_MUL) begin
            draw_bits(2, r);
            issue(fu_op_e'(MUL + r % 3), 4'b1000, 1'b0);
            draw_bits(2, r);
            if (r[1:0] == 2'd0) begin
                drive_idle(1'b0, 1'b1);
            end else if (r[1:0] == 2'd1) begin
                drive_idle(1'b0, 1'b0);
            end
        end
        close_test("mul");

        $display("%0d tests, %0d failed, %0d errors", tests_run, tests_bad, err_cnt);
        if (err_cnt == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(RUN_CYCLES * 4 + 200);
        $display("Watchdog expired at %0d ns, the tests did not complete", $time);
        $display("Something failed");
        $finish;
    end

endmodule

//--- verilog/ex_stage.sv
// Top level of the fixed-latency execute stage, one issue port and one write-back port
`timescale 1ns/10ps

module ex_stage (
    input  logic                             clk_i,
    input  logic                             rst_ni,
    input  logic                             flush_i,
    input  ex_pkg::fu_data_t                 fu_data_i,
    input  ex_pkg::xlen_t                    pc_i,
    input  logic                             is_compressed_i,
    input  logic                             alu_valid_i,
    input  logic                             branch_valid_i,
    input  logic                             csr_valid_i,
    input  logic                             mult_valid_i,
    input  logic                             csr_commit_i,
    input  ex_pkg::branch_predict_t          branch_predict_i,
    output ex_pkg::xlen_t                    flu_result_o,
    output ex_pkg::trans_id_t                flu_trans_id_o,
    output ex_pkg::exception_t               flu_exception_o,
    output logic                             flu_valid_o,
    output logic                             flu_ready_o,
    output ex_pkg::bp_resolve_t              resolved_branch_o,
    output logic                             resolve_branch_o,
    output logic [ex_pkg::CSR_ADDR_BITS-1:0] csr_addr_o
);
    import ex_pkg::*;

    // Silenced operands
    fu_data_t  alu_data;
    fu_data_t  mult_data;
    // Unit results
    xlen_t     alu_result;
    logic      alu_branch_res;
    xlen_t     branch_result;
    xlen_t     csr_result;
    logic      csr_ready;
    xlen_t     mult_result;
    logic      mult_valid;
    trans_id_t mult_trans_id;
    // Non-branch issue, for stray predictions
    logic      other_fu_valid;

    // ----------------------------------------
    // ALU, also compares for branches
    // ----------------------------------------
    assign alu_data = (alu_valid_i | branch_valid_i) ? fu_data_i : '0;

    ex_alu alu_i (
        .fu_data_i    ( alu_data       ),
        .result_o     ( alu_result     ),
        .branch_res_o ( alu_branch_res )
    );

    // ----------------------------------------
    // Branch unit
    // ----------------------------------------
    assign other_fu_valid = alu_valid_i | csr_valid_i | mult_valid_i;

    // Unsilenced, keeps the target path short
    ex_branch_unit branch_unit_i (
        .fu_data_i,
        .pc_i,
        .is_compressed_i,
        .branch_valid_i,
        .fu_valid_i         ( other_fu_valid   ),
        .branch_comp_res_i  ( alu_branch_res   ),
        .branch_predict_i,
        .branch_result_o    ( branch_result    ),
        .resolved_branch_o,
        .resolve_branch_o,
        .branch_exception_o ( flu_exception_o  )
    );

    // CSR buffer, its fill level blocks issue
    ex_csr_buffer csr_buffer_i (
        .clk_i,
        .rst_ni,
        .flush_i,
        .fu_data_i,
        .csr_valid_i,
        .csr_commit_i,
        .csr_ready_o  ( csr_ready  ),
        .csr_result_o ( csr_result ),
        .csr_addr_o
    );

    assign flu_ready_o = csr_ready;

    // ----------------------------------------
    // Multiplier
    // ----------------------------------------
    assign mult_data = mult_valid_i ? fu_data_i : '0;

    ex_multiplier mult_i (
        .clk_i,
        .rst_ni,
        .flush_i,
        .mult_valid_i,
        .fu_data_i       ( mult_data     ),
        .result_o        ( mult_result   ),
        .mult_valid_o    ( mult_valid    ),
        .mult_trans_id_o ( mult_trans_id )
    );

    // ----------------------------------------
    // Write-back
    // ----------------------------------------
    assign flu_valid_o = alu_valid_i | branch_valid_i | csr_valid_i | mult_valid;

    // Priority ALU, CSR, multiplier; link value otherwise
    always_comb begin
        flu_result_o   = branch_result;
        flu_trans_id_o = fu_data_i.trans_id;
        if (alu_valid_i) begin
            flu_result_o = alu_result;
        end else if (csr_valid_i) begin
            flu_result_o = csr_result;
        end else if (mult_valid) begin
            // Product brings its own ID from the issue cycle
            flu_result_o   = mult_result;
            flu_trans_id_o = mult_trans_id;
        end
    end

endmodule

//--- verilog/ex_multiplier.sv
// One-cycle multiplier of the execute stage for MUL, MULH and MULHU with its transaction ID
`timescale 1ns/10ps

module ex_multiplier (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              flush_i,
    input  logic              mult_valid_i,
    input  ex_pkg::fu_data_t  fu_data_i,
    output ex_pkg::xlen_t     result_o,
    output logic              mult_valid_o,
    output ex_pkg::trans_id_t mult_trans_id_o
);
    import ex_pkg::*;

    // Operands widened by one sign or zero bit
    logic                  sign_a;
    logic                  sign_b;
    logic [2*XLEN-1:0]     product;
    xlen_t                 result_d;
    xlen_t                 result_q;
    logic                  valid_q;
    trans_id_t             trans_id_q;

    // ----------------------------------------
    // Product
    // ----------------------------------------
    // Only MULH treats both operands as signed
    assign sign_a = (fu_data_i.operation == MULH) & fu_data_i.operand_a[XLEN-1];
    assign sign_b = (fu_data_i.operation == MULH) & fu_data_i.operand_b[XLEN-1];

    assign product = $signed({sign_a, fu_data_i.operand_a})
                   * $signed({sign_b, fu_data_i.operand_b});

    // Low half for MUL, high half otherwise
    assign result_d = (fu_data_i.operation == MUL) ? product[XLEN-1:0]
                                                   : product[2*XLEN-1:XLEN];

    // ----------------------------------------
    // Output register
    // ----------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= mult_valid_i & ~flush_i;
        end
    end

    always_ff @(posedge clk_i) begin
        result_q   <= result_d;
        trans_id_q <= fu_data_i.trans_id;
    end

    // A flush also kills the product waiting on the port
    assign mult_valid_o    = valid_q & ~flush_i;
    assign result_o        = result_q;
    assign mult_trans_id_o = trans_id_q;

endmodule

//--- verilog/ex_csr_buffer.sv
// Single-entry CSR address buffer of the execute stage, holds the address until commit or flush
`timescale 1ns/10ps

module ex_csr_buffer (
    input  logic                             clk_i,
    input  logic                             rst_ni,
    input  logic                             flush_i,
    input  ex_pkg::fu_data_t                 fu_data_i,
    input  logic                             csr_valid_i,
    input  logic                             csr_commit_i,
    output logic                             csr_ready_o,
    output ex_pkg::xlen_t                    csr_result_o,
    output logic [ex_pkg::CSR_ADDR_BITS-1:0] csr_addr_o
);
    import ex_pkg::*;

    logic                     full_q;
    logic [CSR_ADDR_BITS-1:0] addr_q;

    // Write data goes straight to write-back
    assign csr_result_o = fu_data_i.operand_a;
    assign csr_addr_o   = addr_q;

    // Free again in the commit cycle
    assign csr_ready_o = ~full_q | csr_commit_i;

    // ----------------------------------------
    // Occupancy
    // ----------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            full_q <= 1'b0;
        end else if (flush_i) begin
            full_q <= 1'b0;
        end else if (csr_valid_i) begin
            // New entry, also when the old one commits now
            full_q <= 1'b1;
        end else if (csr_commit_i) begin
            full_q <= 1'b0;
        end
    end

    // Address from the low bits of operand b
    always_ff @(posedge clk_i) begin
        if (csr_valid_i) begin
            addr_q <= fu_data_i.operand_b[CSR_ADDR_BITS-1:0];
        end
    end

endmodule

//--- verilog/ex_branch_unit.sv
// Branch unit of the execute stage, resolves branches and jumps against the front end prediction
`timescale 1ns/10ps

module ex_branch_unit (
    input  ex_pkg::fu_data_t        fu_data_i,
    input  ex_pkg::xlen_t           pc_i,
    input  logic                    is_compressed_i,
    input  logic                    branch_valid_i,
    input  logic                    fu_valid_i,
    input  logic                    branch_comp_res_i,
    input  ex_pkg::branch_predict_t branch_predict_i,
    output ex_pkg::xlen_t           branch_result_o,
    output ex_pkg::bp_resolve_t     resolved_branch_o,
    output logic                    resolve_branch_o,
    output ex_pkg::exception_t      branch_exception_o
);
    import ex_pkg::*;

    logic  is_jump;
    logic  is_taken;
    logic  stray_predict;
    xlen_t target_address;
    xlen_t next_pc;

    assign is_jump = (fu_data_i.operation == JAL) || (fu_data_i.operation == JALR);

    // ----------------------------------------
    // Target and link
    // ----------------------------------------
    always_comb begin
        // JALR is register relative, bit 0 dropped
        if (fu_data_i.operation == JALR) begin
            target_address = (fu_data_i.operand_a + fu_data_i.imm) & ~xlen_t'(1);
        end else begin
            target_address = pc_i + fu_data_i.imm;
        end
    end

    // Fall-through address, also the link value
    assign next_pc         = pc_i + (is_compressed_i ? xlen_t'(2) : xlen_t'(4));
    assign branch_result_o = next_pc;

    // Jumps always taken
    assign is_taken = is_jump | branch_comp_res_i;

    // Taken prediction on something that is no branch
    assign stray_predict    = fu_valid_i & branch_predict_i.valid;
    assign resolve_branch_o = branch_valid_i | stray_predict;

    // ----------------------------------------
    // Resolution
    // ----------------------------------------
    always_comb begin
        resolved_branch_o                = '0;
        resolved_branch_o.pc             = pc_i;
        resolved_branch_o.target_address = next_pc;
        if (branch_valid_i) begin
            resolved_branch_o.valid          = 1'b1;
            resolved_branch_o.is_taken       = is_taken;
            resolved_branch_o.target_address = is_taken ? target_address : next_pc;
            // Wrong direction, or right direction to the wrong place
            resolved_branch_o.is_mispredict  = (branch_predict_i.valid != is_taken)
                || (is_taken && (branch_predict_i.predict_address != target_address));
        end else if (stray_predict) begin
            // Front end went elsewhere, send it back to the next instruction
            resolved_branch_o.valid         = 1'b1;
            resolved_branch_o.is_mispredict = 1'b1;
        end
    end

    // Taken target must be 4-byte aligned
    always_comb begin
        branch_exception_o       = '0;
        branch_exception_o.cause = EXC_INSTR_MISALIGNED;
        branch_exception_o.tval  = target_address;
        branch_exception_o.valid = branch_valid_i & is_taken & target_address[1];
    end

endmodule

//--- verilog/ex_alu.sv
// Single-cycle ALU of the execute stage, also evaluates branch comparisons for the branch unit
`timescale 1ns/10ps

module ex_alu (
    input  ex_pkg::fu_data_t fu_data_i,
    output ex_pkg::xlen_t    result_o,
    output logic             branch_res_o
);
    import ex_pkg::*;

    // Shared adder, runs as subtractor when negating operand b
    logic                    adder_sub;
    xlen_t                   operand_b_neg;
    xlen_t                   adder_result;
    logic                    adder_zero;
    // Comparison
    logic                    is_signed;
    logic                    less;
    logic [$clog2(XLEN)-1:0] shamt;

    // ----------------------------------------
    // Adder and subtractor
    // ----------------------------------------
    always_comb begin
        case (fu_data_i.operation)
            SUB, SLTS, SLTU, EQ, NE, LTS, GES, LTU, GEU: adder_sub = 1'b1;
            default: adder_sub = 1'b0;
        endcase
    end

    // Two's complement negation, carry in via the added one
    assign operand_b_neg = adder_sub ? ~fu_data_i.operand_b : fu_data_i.operand_b;
    assign adder_result  = fu_data_i.operand_a + operand_b_neg + xlen_t'(adder_sub);
    assign adder_zero    = (adder_result == '0);

    // ----------------------------------------
    // Less-than
    // ----------------------------------------
    assign is_signed = (fu_data_i.operation == SLTS) || (fu_data_i.operation == LTS)
                    || (fu_data_i.operation == GES);

    always_comb begin
        // Same sign, difference sign decides
        if (fu_data_i.operand_a[XLEN-1] == fu_data_i.operand_b[XLEN-1]) begin
            less = adder_result[XLEN-1];
        end else begin
            // Signs differ, top bit alone decides
            less = is_signed ? fu_data_i.operand_a[XLEN-1] : fu_data_i.operand_b[XLEN-1];
        end
    end

    // Branch condition
    always_comb begin
        case (fu_data_i.operation)
            EQ:       branch_res_o = adder_zero;
            NE:       branch_res_o = ~adder_zero;
            LTS, LTU: branch_res_o = less;
            GES, GEU: branch_res_o = ~less;
            default:  branch_res_o = 1'b0;
        endcase
    end

    // ----------------------------------------
    // Result select
    // ----------------------------------------
    assign shamt = fu_data_i.operand_b[$clog2(XLEN)-1:0];

    always_comb begin
        case (fu_data_i.operation)
            ADD, SUB:   result_o = adder_result;
            XORL:       result_o = fu_data_i.operand_a ^ fu_data_i.operand_b;
            ORL:        result_o = fu_data_i.operand_a | fu_data_i.operand_b;
            ANDL:       result_o = fu_data_i.operand_a & fu_data_i.operand_b;
            SLL:        result_o = fu_data_i.operand_a << shamt;
            SRL:        result_o = fu_data_i.operand_a >> shamt;
            SRA:        result_o = xlen_t'($signed(fu_data_i.operand_a) >>> shamt);
            SLTS, SLTU: result_o = {{(XLEN-1){1'b0}}, less};
            default:    result_o = '0;
        endcase
    end

endmodule

//--- verilog/ex_pkg.sv
// Widths, operation codes and shared structs of the execute stage; every module imports it
package ex_pkg;

    // ----------------------------------------
    // Widths
    // ----------------------------------------
    localparam int unsigned XLEN           = 32;
    localparam int unsigned TRANS_ID_BITS  = 3;
    localparam int unsigned CSR_ADDR_BITS  = 12;
    localparam int unsigned EXC_CAUSE_BITS = 5;

    typedef logic [XLEN-1:0]          xlen_t;
    typedef logic [TRANS_ID_BITS-1:0] trans_id_t;

    // Instruction address misaligned
    localparam logic [EXC_CAUSE_BITS-1:0] EXC_INSTR_MISALIGNED = 5'd0;

    // ----------------------------------------
    // Operations
    // ----------------------------------------
    typedef enum logic [4:0] {
        // Arithmetic and logic
        ADD, SUB, XORL, ORL, ANDL,
        // Shifts
        SLL, SRL, SRA,
        // Set less than
        SLTS, SLTU,
        // Conditional branches, compared in the ALU
        EQ, NE, LTS, GES, LTU, GEU,
        // Unconditional jumps
        JAL, JALR,
        // CSR access
        CSR_RW,
        // Multiply, low and high halves
        MUL, MULH, MULHU
    } fu_op_e;

    // ----------------------------------------
    // Structs
    // ----------------------------------------
    // Issued instruction on the shared port
    typedef struct packed {
        fu_op_e    operation;
        xlen_t     operand_a;
        xlen_t     operand_b;
        xlen_t     imm;
        trans_id_t trans_id;
    } fu_data_t;

    // Front end prediction, valid means predicted taken
    typedef struct packed {
        logic  valid;
        xlen_t predict_address;
    } branch_predict_t;

    // Resolved control flow back to the front end
    typedef struct packed {
        logic  valid;
        xlen_t pc;
        xlen_t target_address;
        logic  is_taken;
        logic  is_mispredict;
    } bp_resolve_t;

    typedef struct packed {
        logic                      valid;
        logic [EXC_CAUSE_BITS-1:0] cause;
        xlen_t                     tval;
    } exception_t;

endpackage
